/* logic/ddrCmdPkg.sv */
// shared definitions for the DDR2 command scheduler
// address field widths, command and classification enums,
// request struct and default timing limits in controller clocks

package ddrCmdPkg;

   // --------------------
   // address fields
   localparam int RowW     = 14;            // 16K rows
   localparam int BankW    = 3;             // 8 banks
   localparam int ColW     = 8;             // burst-aligned column
   localparam int AddrW    = 26;            // rank + row + bank + col
   localparam int NumRanks = 2;

   // --------------------
   // encodings
   typedef enum logic [2:0] {
      NopCmd       = 3'b111,
      ActiveCmd    = 3'b011,
      ReadCmd      = 3'b101,
      WriteCmd     = 3'b100,
      PrechargeCmd = 3'b010
   } ddrCmdE;                               // {RAS, CAS, WE}

   typedef enum logic [1:0] {
      AccHit,
      AccMiss,
      AccConflict
   } accessE;

   typedef enum logic [1:0] {
      SIdle,
      SWaitAct,
      SIssueOp
   } schedStateE;

   typedef struct packed {
      logic             isRead;
      logic             rank;
      logic [RowW-1:0]  row;
      logic [BankW-1:0] bank;
      logic [ColW-1:0]  col;
   } ddrReqT;

   // --------------------
   // timing limits
   localparam int DefTRtw     = 2;          // read to write
   localparam int DefTWtr     = 5;          // write to read
   localparam int DefTRpa     = 3;          // precharge to activate
   localparam int DefTRtp     = 3;          // read to precharge
   localparam int DefTWtp     = 6;          // write to precharge
   localparam int DefTRas     = 6;          // activate to precharge
   localparam int DefTFaw     = 5;          // activate window length
   localparam int MaxActInWin = 4;

endpackage

/* logic/ddrReqIf.sv */
// pending request bus between intake, row table, timing guard and scheduler
// carries the held request, its valid flag, the take pulse and the class

`timescale 1ns/1ps

interface ddrReqIf ();
   import ddrCmdPkg::*;

   ddrReqT req;                             // held request
   logic   reqValid;
   logic   reqTake;                         // final op issued, register may refill
   accessE access;                          // hit / miss / conflict

   modport intake   (output req, output reqValid, input reqTake);
   modport sched    (input req, input reqValid, input access, output reqTake);
   modport rowTable (input req, output access);
   modport guard    (input req);

endinterface

/* logic/reqIntake.sv */
// Wishbone classic slave without data lines
// one-entry request register with posted acknowledge
// address split into rank, row, bank and column

`timescale 1ns/1ps

module reqIntake (
   input  logic                          CLK,
   input  logic                          rst,
   input  logic                          wbCyc,
   input  logic                          wbStb,
   input  logic                          wbWe,
   input  logic [ddrCmdPkg::AddrW-1:0]   wbAdr,
   output logic                          wbAck,
   ddrReqIf.intake                       reqPort
);
   import ddrCmdPkg::*;

   logic accept;

   // master keeps strobe up during the ack cycle, so that cycle is masked
   assign accept = wbCyc && wbStb && !wbAck &&
                   (!reqPort.reqValid || reqPort.reqTake);

   // --------------------
   // handshake
   always_ff @(posedge CLK) begin
      if (rst) begin
         wbAck            <= 1'b0;
         reqPort.reqValid <= 1'b0;
      end else begin
         wbAck            <= accept;      // one pulse per accepted request
         reqPort.reqValid <= accept || (reqPort.reqValid && !reqPort.reqTake);
      end
   end

   // --------------------
   // request register
   always_ff @(posedge CLK) begin
      if (accept) begin
         reqPort.req.isRead <= !wbWe;                          // we low = read
         reqPort.req.rank   <= wbAdr[AddrW-1];
         reqPort.req.row    <= wbAdr[AddrW-2 -: RowW];
         reqPort.req.bank   <= wbAdr[BankW+ColW-1 -: BankW];
         reqPort.req.col    <= wbAdr[ColW-1:0];
      end
   end

endmodule

/* logic/openRowTable.sv */
// open-row memory, one row and valid bit per rank and bank
// activate opens a row, precharge closes the bank
// classifies the held request as hit, miss or conflict

`timescale 1ns/1ps

module openRowTable (
   input  logic                        CLK,
   input  logic                        rst,
   ddrReqIf.rowTable                   reqPort,
   input  logic                        actIssue,
   input  logic                        preIssue,
   input  logic                        cmdRank,
   input  logic [ddrCmdPkg::BankW-1:0] cmdBank,
   input  logic [ddrCmdPkg::RowW-1:0]  cmdRow
);
   import ddrCmdPkg::*;

   localparam int NumBanks = 2 ** BankW;

   logic [NumBanks-1:0] bankOpen [NumRanks];
   logic [RowW-1:0]     openRow  [NumRanks][NumBanks];
   logic                reqOpen;
   logic                rowMatch;

   // --------------------
   // bank state
   always_ff @(posedge CLK) begin
      if (rst) begin
         for (int r = 0; r < NumRanks; r++) begin
            bankOpen[r] <= '0;                 // all banks closed
         end
      end else if (actIssue) begin
         bankOpen[cmdRank][cmdBank] <= 1'b1;
      end else if (preIssue) begin
         bankOpen[cmdRank][cmdBank] <= 1'b0;
      end
   end

   always_ff @(posedge CLK) begin
      if (actIssue) begin
         openRow[cmdRank][cmdBank] <= cmdRow;
      end
   end

   // --------------------
   // classification
   assign reqOpen  = bankOpen[reqPort.req.rank][reqPort.req.bank];
   assign rowMatch = openRow[reqPort.req.rank][reqPort.req.bank] == reqPort.req.row;

   always_comb begin
      if (!reqOpen) begin
         reqPort.access = AccMiss;            // activate first
      end else if (rowMatch) begin
         reqPort.access = AccHit;
      end else begin
         reqPort.access = AccConflict;        // precharge, activate, op
      end
   end

endmodule

/* logic/timingGuard.sv */
// timing guard for the command stream
// global read, write and precharge gap timers
// per-rank activate, read and write timers and the activate window
// permission flags for the held request's rank

`timescale 1ns/1ps

module timingGuard #(
   parameter int TRtw = ddrCmdPkg::DefTRtw,
   parameter int TWtr = ddrCmdPkg::DefTWtr,
   parameter int TRpa = ddrCmdPkg::DefTRpa,
   parameter int TRtp = ddrCmdPkg::DefTRtp,
   parameter int TWtp = ddrCmdPkg::DefTWtp,
   parameter int TRas = ddrCmdPkg::DefTRas,
   parameter int TFaw = ddrCmdPkg::DefTFaw
) (
   input  logic              CLK,
   input  logic              rst,
   ddrReqIf.guard            reqPort,
   input  ddrCmdPkg::ddrCmdE issuedCmd,
   input  logic              issuedRank,
   output logic              opOk,
   output logic              preOk,
   output logic              actOk
);
   import ddrCmdPkg::*;

   // the command in flight blocks its own cycle and the next decision
   // lands one clock later, so a gap of t needs a load of t-2
   function automatic logic [3:0] loadVal(input int t);
      return (t > 2) ? 4'(t - 2) : 4'd0;
   endfunction

   localparam logic [3:0] LRtw = loadVal(TRtw);
   localparam logic [3:0] LWtr = loadVal(TWtr);
   localparam logic [3:0] LRpa = loadVal(TRpa);
   localparam logic [3:0] LRtp = loadVal(TRtp);
   localparam logic [3:0] LWtp = loadVal(TWtp);
   localparam logic [3:0] LRas = loadVal(TRas);

   logic [3:0]      tLastRd, tLastWr, tLastPre;
   logic [3:0]      tAct   [NumRanks];
   logic [3:0]      tRd    [NumRanks];
   logic [3:0]      tWr    [NumRanks];
   logic [TFaw-1:0] actWin [NumRanks];           // one bit per past clock
   logic            isRd, isWr, isAct, isPre;
   logic            rankBusy;
   logic [3:0]      actCount;

   assign isRd  = issuedCmd == ReadCmd;
   assign isWr  = issuedCmd == WriteCmd;
   assign isAct = issuedCmd == ActiveCmd;
   assign isPre = issuedCmd == PrechargeCmd;

   // --------------------
   // global timers
   always_ff @(posedge CLK) begin
      if (rst) begin
         tLastRd  <= '0;
         tLastWr  <= '0;
         tLastPre <= '0;
      end else begin
         tLastRd  <= isRd  ? LRtw : (tLastRd  != 0) ? tLastRd  - 1'b1 : tLastRd;
         tLastWr  <= isWr  ? LWtr : (tLastWr  != 0) ? tLastWr  - 1'b1 : tLastWr;
         tLastPre <= isPre ? LRpa : (tLastPre != 0) ? tLastPre - 1'b1 : tLastPre;
      end
   end

   // --------------------
   // per-rank timers and activate window
   always_ff @(posedge CLK) begin
      if (rst) begin
         for (int r = 0; r < NumRanks; r++) begin
            tAct[r]   <= '0;
            tRd[r]    <= '0;
            tWr[r]    <= '0;
            actWin[r] <= '0;
         end
      end else begin
         for (int r = 0; r < NumRanks; r++) begin
            if (isAct && issuedRank == 1'(r)) begin
               tAct[r] <= LRas;
            end else if (tAct[r] != 0) begin
               tAct[r] <= tAct[r] - 1'b1;
            end
            if (isRd && issuedRank == 1'(r)) begin
               tRd[r] <= LRtp;
            end else if (tRd[r] != 0) begin
               tRd[r] <= tRd[r] - 1'b1;
            end
            if (isWr && issuedRank == 1'(r)) begin
               tWr[r] <= LWtp;
            end else if (tWr[r] != 0) begin
               tWr[r] <= tWr[r] - 1'b1;
            end
            actWin[r] <= {actWin[r][TFaw-2:0], isAct && issuedRank == 1'(r)};
         end
      end
   end

   // activates seen on this rank, the one on the pins now included
   always_comb begin
      actCount = {3'b000, isAct && issuedRank == reqPort.req.rank};
      for (int i = 0; i < TFaw; i++) begin
         actCount = actCount + {3'b000, actWin[reqPort.req.rank][i]};
      end
   end

   // --------------------
   // permission flags
   assign rankBusy = issuedRank == reqPort.req.rank && (isAct || isRd || isWr);

   assign opOk  = reqPort.req.isRead ? (tLastWr == 0 && !isWr)
                                     : (tLastRd == 0 && !isRd);
   assign preOk = tAct[reqPort.req.rank] == 0 && tRd[reqPort.req.rank] == 0 &&
                  tWr[reqPort.req.rank] == 0 && !rankBusy;
   assign actOk = tLastPre == 0 && !isPre && actCount < MaxActInWin;

endmodule

/* logic/cmdScheduler.sv */
// command FSM for hit, miss and conflict sequences
// registered RAS/CAS/WE, address, bank and rank-select outputs

`timescale 1ns/1ps

module cmdScheduler (
   input  logic                        CLK,
   input  logic                        rst,
   input  logic                        inhibit,
   ddrReqIf.sched                      reqPort,
   input  logic                        opOk,
   input  logic                        preOk,
   input  logic                        actOk,
   output ddrCmdPkg::ddrCmdE           issuedCmd,
   output logic                        issuedRank,
   output logic                        actIssue,
   output logic                        preIssue,
   output logic [ddrCmdPkg::BankW-1:0] cmdBank,
   output logic [ddrCmdPkg::RowW-1:0]  cmdRow,
   output logic                        ddrRas,
   output logic                        ddrCas,
   output logic                        ddrWe,
   output logic [ddrCmdPkg::RowW-1:0]  ddrAddr,
   output logic [ddrCmdPkg::BankW-1:0] ddrBank,
   output logic [1:0]                  ddrRankSel
);
   import ddrCmdPkg::*;

   schedStateE state, nextState;
   ddrCmdE     nextCmd;
   ddrCmdE     opCmd;
   logic       opDone;

   assign opCmd = reqPort.req.isRead ? ReadCmd : WriteCmd;

   // --------------------
   // next command
   always_comb begin
      nextState = state;
      nextCmd   = NopCmd;
      opDone    = 1'b0;
      if (reqPort.reqValid && !inhibit) begin
         case (state)
            SIdle: begin
               case (reqPort.access)
                  AccHit: begin
                     if (opOk) begin
                        nextCmd = opCmd;
                        opDone  = 1'b1;
                     end
                  end
                  AccMiss: begin
                     if (actOk) begin
                        nextCmd   = ActiveCmd;
                        nextState = SIssueOp;
                     end
                  end
                  default: begin                       // conflict
                     if (preOk) begin
                        nextCmd   = PrechargeCmd;
                        nextState = SWaitAct;
                     end
                  end
               endcase
            end
            SWaitAct: begin
               if (actOk) begin
                  nextCmd   = ActiveCmd;
                  nextState = SIssueOp;
               end
            end
            default: begin                             // SIssueOp
               if (opOk) begin
                  nextCmd   = opCmd;
                  opDone    = 1'b1;
                  nextState = SIdle;
               end
            end
         endcase
      end
   end

   assign reqPort.reqTake = opDone;

   // --------------------
   // output stage
   always_ff @(posedge CLK) begin
      if (rst) begin
         state      <= SIdle;
         issuedCmd  <= NopCmd;
         ddrRankSel <= 2'b11;                  // both ranks deselected
      end else begin
         state      <= nextState;
         issuedCmd  <= nextCmd;
         if (nextCmd == NopCmd) begin
            ddrRankSel <= 2'b11;
         end else begin
            ddrRankSel <= reqPort.req.rank ? 2'b01 : 2'b10;   // active low
         end
      end
   end

   always_ff @(posedge CLK) begin
      issuedRank <= reqPort.req.rank;
      ddrBank    <= reqPort.req.bank;
      case (nextCmd)
         ActiveCmd: ddrAddr <= reqPort.req.row;
         ReadCmd, WriteCmd: ddrAddr <= {{(RowW-ColW-2){1'b0}}, reqPort.req.col, 2'b00};
         default: ddrAddr <= '0;               // A10 low, single-bank precharge
      endcase
   end

   assign {ddrRas, ddrCas, ddrWe} = issuedCmd;
   assign actIssue = issuedCmd == ActiveCmd;
   assign preIssue = issuedCmd == PrechargeCmd;
   assign cmdBank  = ddrBank;
   assign cmdRow   = ddrAddr;                  // row sits on the pins during activate

endmodule

/* logic/ddrCmdTop.sv */
// DDR2 command scheduler top level
// request intake, open-row table, timing guard and command FSM

`timescale 1ns/1ps

module ddrCmdTop #(
   parameter int TRtw = ddrCmdPkg::DefTRtw,
   parameter int TWtr = ddrCmdPkg::DefTWtr,
   parameter int TRpa = ddrCmdPkg::DefTRpa,
   parameter int TRtp = ddrCmdPkg::DefTRtp,
   parameter int TWtp = ddrCmdPkg::DefTWtp,
   parameter int TRas = ddrCmdPkg::DefTRas,
   parameter int TFaw = ddrCmdPkg::DefTFaw
) (
   input  logic                        CLK,
   input  logic                        rst,
   input  logic                        inhibit,
   input  logic                        wbCyc,
   input  logic                        wbStb,
   input  logic                        wbWe,
   input  logic [ddrCmdPkg::AddrW-1:0] wbAdr,
   output logic                        wbAck,
   output logic                        ddrRas,
   output logic                        ddrCas,
   output logic                        ddrWe,
   output logic [ddrCmdPkg::RowW-1:0]  ddrAddr,
   output logic [ddrCmdPkg::BankW-1:0] ddrBank,
   output logic [1:0]                  ddrRankSel
);
   import ddrCmdPkg::*;

   ddrReqIf reqBus ();

   ddrCmdE           issuedCmd;
   logic             issuedRank;
   logic             actIssue, preIssue;
   logic             opOk, preOk, actOk;
   logic [BankW-1:0] cmdBank;
   logic [RowW-1:0]  cmdRow;

   reqIntake intake (
      .CLK(CLK), .rst(rst), .wbCyc(wbCyc), .wbStb(wbStb), .wbWe(wbWe),
      .wbAdr(wbAdr), .wbAck(wbAck), .reqPort(reqBus.intake)
   );

   openRowTable rowTable (
      .CLK(CLK), .rst(rst), .reqPort(reqBus.rowTable),
      .actIssue(actIssue), .preIssue(preIssue),
      .cmdRank(issuedRank), .cmdBank(cmdBank), .cmdRow(cmdRow)
   );

   timingGuard #(
      .TRtw(TRtw), .TWtr(TWtr), .TRpa(TRpa), .TRtp(TRtp),
      .TWtp(TWtp), .TRas(TRas), .TFaw(TFaw)
   ) guard (
      .CLK(CLK), .rst(rst), .reqPort(reqBus.guard),
      .issuedCmd(issuedCmd), .issuedRank(issuedRank),
      .opOk(opOk), .preOk(preOk), .actOk(actOk)
   );

   cmdScheduler sched (
      .CLK(CLK), .rst(rst), .inhibit(inhibit), .reqPort(reqBus.sched),
      .opOk(opOk), .preOk(preOk), .actOk(actOk),
      .issuedCmd(issuedCmd), .issuedRank(issuedRank),
      .actIssue(actIssue), .preIssue(preIssue),
      .cmdBank(cmdBank), .cmdRow(cmdRow),
      .ddrRas(ddrRas), .ddrCas(ddrCas), .ddrWe(ddrWe),
      .ddrAddr(ddrAddr), .ddrBank(ddrBank), .ddrRankSel(ddrRankSel)
   );

endmodule

/* tb/ddrCmd_assert.sv */
// timing checks on the issued command stream of the scheduler
// activate to precharge, precharge to activate, read/write turnaround
// and the per-rank activate window

`timescale 1ns/1ps

module ddrCmdTiming (
   input logic              CLK,
   input logic              rst,
   input ddrCmdPkg::ddrCmdE issuedCmd,
   input logic              issuedRank
);
   import ddrCmdPkg::*;

   localparam logic [4:0] SatMax = 5'd31;

   int unsigned        failCount = 0;             // read by the testbench
   logic [4:0]         sinceAct [NumRanks];
   logic [4:0]         sincePre, sinceRd, sinceWr;
   logic [DefTFaw-2:0] actHist  [NumRanks];       // earlier clocks of the window

   function automatic logic [4:0] bump(input logic [4:0] v);
      return (v == SatMax) ? v : v + 1'b1;
   endfunction

   // --------------------
   // distance counters
   always_ff @(posedge CLK) begin
      if (rst) begin
         sincePre <= SatMax;
         sinceRd  <= SatMax;
         sinceWr  <= SatMax;
         for (int r = 0; r < NumRanks; r++) begin
            sinceAct[r] <= SatMax;
            actHist[r]  <= '0;
         end
      end else begin
         sincePre <= (issuedCmd == PrechargeCmd) ? 5'd1 : bump(sincePre);
         sinceRd  <= (issuedCmd == ReadCmd) ? 5'd1 : bump(sinceRd);
         sinceWr  <= (issuedCmd == WriteCmd) ? 5'd1 : bump(sinceWr);
         for (int r = 0; r < NumRanks; r++) begin
            sinceAct[r] <= (issuedCmd == ActiveCmd && issuedRank == 1'(r)) ? 5'd1
                                                                            : bump(sinceAct[r]);
            actHist[r]  <= {actHist[r][DefTFaw-3:0],
                            issuedCmd == ActiveCmd && issuedRank == 1'(r)};
         end
      end
   end

   // --------------------
   // properties
   actToPre: assert property (@(posedge CLK) disable iff (rst)
      issuedCmd == PrechargeCmd |-> sinceAct[issuedRank] >= DefTRas)
      else begin
         $error("precharge too close to activate on the same rank");
         failCount++;
      end

   preToAct: assert property (@(posedge CLK) disable iff (rst)
      issuedCmd == ActiveCmd |-> sincePre >= DefTRpa)
      else begin
         $error("activate too close to precharge");
         failCount++;
      end

   wrToRd: assert property (@(posedge CLK) disable iff (rst)
      issuedCmd == ReadCmd |-> sinceWr >= DefTWtr)
      else begin
         $error("read too close to write");
         failCount++;
      end

   rdToWr: assert property (@(posedge CLK) disable iff (rst)
      issuedCmd == WriteCmd |-> sinceRd >= DefTRtw)
      else begin
         $error("write too close to read");
         failCount++;
      end

   actWindow: assert property (@(posedge CLK) disable iff (rst)
      issuedCmd == ActiveCmd |-> $countones(actHist[issuedRank]) < MaxActInWin)
      else begin
         $error("too many activates inside the window");
         failCount++;
      end

endmodule

bind cmdScheduler ddrCmdTiming timingChecks (
   .CLK(CLK), .rst(rst), .issuedCmd(issuedCmd), .issuedRank(issuedRank)
);

/* tb/ddrCmdTb.sv */
// testbench for the DDR2 command scheduler
// Wishbone master, open-row reference model, pin monitor and compare
// directed hit/miss/conflict, inhibit and random back-to-back phases

`timescale 1ns/1ps

module ddrCmdTb;
   import ddrCmdPkg::*;

   localparam int          NumRand      = 60;
   localparam int          NumReq       = NumRand + 6;     // 4 directed, 2 inhibit
   localparam int          CyclesPerReq = 400;
   localparam logic [31:0] Seed         = 32'hd16ffec3;

   typedef struct packed {
      ddrCmdE           cmd;
      logic             rank;
      logic [BankW-1:0] bank;
      logic [RowW-1:0]  addr;
   } expCmdT;

   logic             CLK = 1'b0;
   logic             rst, inhibit, wbCyc, wbStb, wbWe, wbAck;
   logic [AddrW-1:0] wbAdr;
   logic             ddrRas, ddrCas, ddrWe;
   logic [RowW-1:0]  ddrAddr;
   logic [BankW-1:0] ddrBank;
   logic [1:0]       ddrRankSel;
   ddrCmdE           pinCmd;

   expCmdT           expQ [$];                  // expected non-NOP commands
   logic             modelOpen [NumRanks][2**BankW];
   logic [RowW-1:0]  modelRow  [NumRanks][2**BankW];
   int               valErrors  = 0;
   int               protErrors = 0;
   int               ackCount   = 0;
   int               assertFails;

   always #2 CLK = ~CLK;

   ddrCmdTop uut (
      .CLK(CLK), .rst(rst), .inhibit(inhibit),
      .wbCyc(wbCyc), .wbStb(wbStb), .wbWe(wbWe), .wbAdr(wbAdr), .wbAck(wbAck),
      .ddrRas(ddrRas), .ddrCas(ddrCas), .ddrWe(ddrWe),
      .ddrAddr(ddrAddr), .ddrBank(ddrBank), .ddrRankSel(ddrRankSel)
   );

   assign pinCmd = ddrCmdE'({ddrRas, ddrCas, ddrWe});

   // --------------------
   // reference model and checks
   function automatic logic [AddrW-1:0] makeAdr(input logic rank, input logic [RowW-1:0] row,
                                                input logic [BankW-1:0] bank,
                                                input logic [ColW-1:0] col);
      return {rank, row, bank, col};
   endfunction

   function automatic void predictCmds(input logic isRead, input logic [AddrW-1:0] adr);
      logic             rank;
      logic [RowW-1:0]  row;
      logic [BankW-1:0] bank;
      logic [ColW-1:0]  col;
      rank = adr[25];
      row  = adr[24:11];
      bank = adr[10:8];
      col  = adr[7:0];
      if (modelOpen[rank][bank] && modelRow[rank][bank] != row) begin
         expQ.push_back('{PrechargeCmd, rank, bank, RowW'(0)});   // A10 low
         modelOpen[rank][bank] = 1'b0;
      end
      if (!modelOpen[rank][bank]) begin
         expQ.push_back('{ActiveCmd, rank, bank, row});
         modelOpen[rank][bank] = 1'b1;
         modelRow[rank][bank]  = row;
      end
      expQ.push_back('{isRead ? ReadCmd : WriteCmd, rank, bank, RowW'({col, 2'b00})});
   endfunction

   task automatic checkCmd(input ddrCmdE got, input ddrCmdE exp);
      if (got !== exp) begin
         $display("[ERROR] %0t: command %s, expected %s", $time, got.name(), exp.name());
         valErrors++;
      end
   endtask

   task automatic checkAddr(input logic [RowW-1:0] got, input logic [RowW-1:0] exp,
                            input string what);
      if (got !== exp) begin
         $display("[ERROR] %0t: %s is %h, expected %h", $time, what, got, exp);
         valErrors++;
      end
   endtask

   // posted request, returns on the acknowledge edge
   task automatic sendReq(input logic isRead, input logic [AddrW-1:0] adr);
      wbCyc <= 1'b1;
      wbStb <= 1'b1;
      wbWe  <= !isRead;
      wbAdr <= adr;
      do begin
         @(posedge CLK);
      end while (!wbAck);
      predictCmds(isRead, adr);
   endtask

   task automatic waitDrained();
      while (expQ.size() != 0) begin
         @(posedge CLK);
      end
   endtask

   always @(posedge CLK) begin
      if (!rst && wbAck) begin
         ackCount++;
      end
   end

   // compare every pin command against the model queue
   always @(negedge CLK) begin : monitor
      expCmdT exp;
      if (!rst) begin
         if (pinCmd == NopCmd) begin
            checkAddr(RowW'(ddrRankSel), RowW'(2'b11), "rank select during NOP");
         end else if (expQ.size() == 0) begin
            $display("%0t: command %s appeared with nothing outstanding", $time, pinCmd.name());
            protErrors++;
         end else begin
            exp = expQ.pop_front();
            checkCmd(pinCmd, exp.cmd);
            checkAddr(RowW'(ddrRankSel), RowW'(exp.rank ? 2'b01 : 2'b10), "rank select");
            checkAddr(RowW'(ddrBank), RowW'(exp.bank), "bank");
            checkAddr(ddrAddr, exp.addr, "address");
         end
      end
   end

   initial begin : watchdog
      repeat (CyclesPerReq * NumReq) @(posedge CLK);
      $display("timed out with %0d commands still outstanding", expQ.size());
      $display("Test FAILED");
      $finish;
   end

   // --------------------
   // stimulus
   initial begin
      rst       = 1'b1;
      inhibit   = 1'b0;
      wbCyc     = 1'b0;
      wbStb     = 1'b0;
      wbWe      = 1'b0;
      wbAdr     = '0;
      void'($urandom(Seed));
      for (int r = 0; r < NumRanks; r++) begin
         for (int b = 0; b < 2**BankW; b++) begin
            modelOpen[r][b] = 1'b0;
         end
      end
      repeat (4) @(posedge CLK);
      rst <= 1'b0;
      repeat (4) begin                                 // idle bus after reset
         @(posedge CLK);
         checkCmd(pinCmd, NopCmd);
         if (wbAck) begin
            $display("%0t: acknowledge seen without a strobe", $time);
            protErrors++;
         end
      end

      sendReq(1'b0, makeAdr(1'b0, 14'd5, 3'd2, 8'h11));   // miss
      sendReq(1'b1, makeAdr(1'b0, 14'd5, 3'd2, 8'h12));   // hit
      sendReq(1'b1, makeAdr(1'b0, 14'd9, 3'd2, 8'h13));   // conflict
      sendReq(1'b0, makeAdr(1'b1, 14'd9, 3'd2, 8'h14));   // other rank, miss
      wbCyc <= 1'b0;
      wbStb <= 1'b0;
      waitDrained();

      inhibit <= 1'b1;
      sendReq(1'b1, makeAdr(1'b0, 14'd7, 3'd5, 8'h3c));   // fills the register
      wbWe  <= 1'b1;
      wbAdr <= makeAdr(1'b0, 14'd8, 3'd5, 8'h40);
      repeat (20) begin
         @(posedge CLK);
         if (wbAck) begin
            $display("%0t: request acknowledged while the register was full", $time);
            protErrors++;
         end
         if (pinCmd != NopCmd) begin
            $display("%0t: command %s issued while inhibited", $time, pinCmd.name());
            protErrors++;
         end
      end
      inhibit <= 1'b0;
      sendReq(1'b0, makeAdr(1'b0, 14'd8, 3'd5, 8'h40));
      wbCyc <= 1'b0;
      wbStb <= 1'b0;
      waitDrained();

      for (int i = 0; i < NumRand; i++) begin             // back-to-back, mixed classes
         sendReq(1'($urandom_range(1)),
                 makeAdr(1'($urandom_range(1)), 14'($urandom_range(3, 1)),
                         3'($urandom_range(1)), 8'($urandom)));
      end
      wbCyc <= 1'b0;
      wbStb <= 1'b0;
      waitDrained();
      repeat (10) @(posedge CLK);

      assertFails = uut.sched.timingChecks.failCount;
      if (ackCount != NumReq) begin
         $display("saw %0d acknowledges for %0d requests", ackCount, NumReq);
         protErrors++;
      end
      $display("value errors %0d, other errors %0d, assertion failures %0d",
               valErrors, protErrors, assertFails);
      if (valErrors == 0 && protErrors == 0 && assertFails == 0) begin
         $display("Test OK");
      end else begin
         $display("Test FAILED");
      end
      $finish;
   end

endmodule

/* sim.f */
logic/ddrCmdPkg.sv
logic/ddrReqIf.sv
logic/reqIntake.sv
logic/openRowTable.sv
logic/timingGuard.sv
logic/cmdScheduler.sv
logic/ddrCmdTop.sv
tb/ddrCmd_assert.sv
tb/ddrCmdTb.sv

/* Bender.yml */
package:
  name: ddr_cmd_sched

sources:
  - files:
      - logic/ddrCmdPkg.sv
      - logic/ddrReqIf.sv
      - logic/reqIntake.sv
      - logic/openRowTable.sv
      - logic/timingGuard.sv
      - logic/cmdScheduler.sv
      - logic/ddrCmdTop.sv
  - target: simulation
    files:
      - tb/ddrCmd_assert.sv
      - tb/ddrCmdTb.sv
